/* Bender.yml */
package:
  name: prefetch

sources:
  - logic/prefetch_pkg.sv
  - logic/fetch_req_if.sv
  - logic/prefetch_window.sv
  - logic/fetch_fsm.sv
  - logic/fetch_timer.sv
  - logic/prefetch_fifo.sv
  - logic/prefetch_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_prefetch.sv

/* all.f */
logic/prefetch_pkg.sv
logic/fetch_req_if.sv
logic/prefetch_window.sv
logic/fetch_fsm.sv
logic/fetch_timer.sv
logic/prefetch_fifo.sv
logic/prefetch_top.sv
tb/tb_clock_gen.sv
tb/tb_prefetch.sv

/* logic/fetch_fsm.sv */
// fetch sequencer: APB word reads, byte count and alignment, flush discard and fault capture.
`timescale 1ns/1ps

module fetch_fsm
    import prefetch_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        pr_reset,
    input  logic        flush,
    input  logic [1:0]  cpl,
    fetch_req_if.fetcher req,
    output addr_t       paddr,
    output logic        psel,
    output logic        penable,
    output logic        pprot_priv,
    input  word_t       prdata,
    input  logic        pready,
    input  logic        pslverr,
    output logic        counting,
    input  logic        expired,
    input  logic [2:0]  occupancy,
    output logic        push,
    output word_t       push_data,
    output byte_cnt_t   push_count,
    output logic        fault,
    output fault_e      fault_cause
);

    fetch_state_e state;
    addr_t        paddr_q;
    logic [1:0]   offset_q;
    byte_cnt_t    count_q;
    logic         discard;
    logic         priv_q;
    fault_e       cause_q;
    logic         start;
    byte_cnt_t    avail;
    byte_cnt_t    count_next;
    logic         accept;
    logic         bus_error;

    // bytes left in the word from the current address.
    assign avail = byte_cnt_t'(3'd4 - {1'b0, req.address[1:0]});

    // clip to the segment budget.
    assign count_next = (req.budget < addr_t'(avail)) ? byte_cnt_t'(req.budget) : avail;

    // a flush in idle holds off the start so the new window is used.
    assign start = (state == FS_IDLE) && !flush && (req.budget != '0) &&
                   (cause_q == FAULT_NONE) && (int'(occupancy) < FIFO_DEPTH);

    // completed read that still belongs to the current window.
    assign accept = (state == FS_ACCESS) && pready && !pslverr && !discard &&
                    !flush && (req.budget != '0);

    // errors on discarded transfers are stale and ignored.
    assign bus_error = pready && pslverr && !discard && !flush;

    // APB master outputs come straight from the state.
    assign psel       = (state == FS_SETUP) || (state == FS_ACCESS);
    assign penable    = (state == FS_ACCESS);
    assign paddr      = paddr_q;
    assign pprot_priv = priv_q;

    // the timer runs only while waiting for pready.
    assign counting = (state == FS_ACCESS);

    // first wanted byte lands in lane 0.
    assign push       = accept;
    assign push_data  = prdata >> {offset_q, 3'b000};
    assign push_count = count_q;

    // window advances in the same edge as the push.
    assign req.done       = accept;
    assign req.done_count = count_q;

    assign fault       = (cause_q != FAULT_NONE);
    assign fault_cause = cause_q;

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            state   <= FS_IDLE;
            discard <= 1'b0;
            priv_q  <= 1'b1;
            cause_q <= FAULT_NONE;
        end else begin
            // privilege is reloaded with the window.
            if (flush) begin
                priv_q <= (cpl != 2'd3);
            end
            case (state)
                FS_IDLE: begin
                    if (start) begin
                        state   <= FS_SETUP;
                        discard <= 1'b0;
                    end
                end
                FS_SETUP: begin
                    state <= FS_ACCESS;
                    if (flush) begin
                        discard <= 1'b1;
                    end
                end
                FS_ACCESS: begin
                    // transfer runs to the end on the bus either way.
                    if (flush) begin
                        discard <= 1'b1;
                    end
                    if (pready) begin
                        if (bus_error) begin
                            state   <= FS_HALT;
                            cause_q <= FAULT_SLVERR;
                        end else begin
                            state <= FS_IDLE;
                        end
                    end else if (expired) begin
                        // give up on a hung slave and release psel.
                        state   <= FS_HALT;
                        cause_q <= FAULT_TIMEOUT;
                    end
                end
                FS_HALT: begin
                    // only a new window restarts fetching.
                    if (flush) begin
                        state   <= FS_IDLE;
                        cause_q <= FAULT_NONE;
                    end
                end
                default: begin
                    state <= FS_IDLE;
                end
            endcase
        end
    end

    // transfer address and byte slice, held for the whole transfer.
    always_ff @(posedge clk) begin
        if (start) begin
            paddr_q  <= {req.address[ADDR_W-1:2], 2'b00};
            offset_q <= req.address[1:0];
            count_q  <= count_next;
        end
    end

endmodule

/* logic/fetch_req_if.sv */
// fetch request link: window address and budget out, completed byte count back.
`timescale 1ns/1ps

interface fetch_req_if
    import prefetch_pkg::*;
();

    // current linear address of the next byte to fetch.
    addr_t     address;
    // bytes still allowed before the segment limit.
    addr_t     budget;
    // one-cycle strobe when a group was pushed.
    logic      done;
    // bytes consumed by that group.
    byte_cnt_t done_count;

    // the window owns address and budget.
    modport window (
        output address,
        output budget,
        input  done,
        input  done_count
    );

    // the fetcher reports progress.
    modport fetcher (
        input  address,
        input  budget,
        output done,
        output done_count
    );

endinterface

/* logic/fetch_timer.sv */
// wait-state timer: flags an APB access that runs too long.
`timescale 1ns/1ps

module fetch_timer #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk,
    input  logic pr_reset,
    input  logic counting,
    output logic expired
);

    // wide enough to hold the limit itself.
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count;

    // access cycles seen so far; saturates at the limit.
    always_ff @(posedge clk) begin
        if (pr_reset) begin
            count <= '0;
        end else if (!counting) begin
            count <= '0;
        end else if (count != CNT_W'(TIMEOUT_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    // high once the full wait budget has passed without pready.
    assign expired = counting && (count == CNT_W'(TIMEOUT_CYCLES));

endmodule

/* logic/prefetch_fifo.sv */
// prefetch FIFO: holds byte groups for the decoder and reports occupancy to the fetcher.
`timescale 1ns/1ps

module prefetch_fifo
    import prefetch_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       pr_reset,
    input  logic       flush,
    input  logic       push,
    input  word_t      push_data,
    input  byte_cnt_t  push_count,
    output logic [2:0] occupancy,
    output logic       out_valid,
    output word_t      out_data,
    output byte_cnt_t  out_count,
    input  logic       out_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    word_t      data_mem [FIFO_DEPTH];
    byte_cnt_t  count_mem[FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic       do_push;
    logic       do_pop;

    // a push into a full buffer is refused.
    assign do_push = push && (int'(occupancy) < FIFO_DEPTH);
    assign do_pop  = out_valid && out_ready;

    // head of the queue toward the decoder.
    assign out_valid = (occupancy != 3'd0);
    assign out_data  = data_mem[rd_ptr];
    assign out_count = count_mem[rd_ptr];

    // pointers wrap at the depth, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (pr_reset || flush) begin
            // flush drops stale groups.
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= 3'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the level unchanged.
            if (do_push && !do_pop) begin
                occupancy <= occupancy + 3'd1;
            end else if (do_pop && !do_push) begin
                occupancy <= occupancy - 3'd1;
            end
        end
    end

    // storage for data and byte count.
    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            data_mem[wr_ptr]  <= push_data;
            count_mem[wr_ptr] <= push_count;
        end
    end

endmodule

/* logic/prefetch_pkg.sv */
// prefetch package: shared widths, descriptor decode and the state and fault encodings.
package prefetch_pkg;

    // address and data paths are one 32-bit word wide.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // granularity flag inside the code-segment descriptor.
    localparam int DESC_G_BIT = 55;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [63:0]       cs_desc_t;

    // number of valid bytes in one group, 0 to 4.
    typedef logic [2:0] byte_cnt_t;

    // APB read sequencer states.
    typedef enum logic [1:0] {
        FS_IDLE,
        FS_SETUP,
        FS_ACCESS,
        FS_HALT
    } fetch_state_e;

    // reason the fetcher stopped.
    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_SLVERR,
        FAULT_TIMEOUT
    } fault_e;

    // segment base is split over two descriptor fields.
    function automatic addr_t desc_base(input cs_desc_t desc);
        return {desc[63:56], desc[39:16]};
    endfunction

    // 20-bit limit, scaled to 4 KiB pages when G is set.
    function automatic addr_t desc_limit(input cs_desc_t desc);
        if (desc[DESC_G_BIT]) begin
            return {desc[51:48], desc[15:0], 12'hfff};
        end
        return {12'd0, desc[51:48], desc[15:0]};
    endfunction

endpackage

/* logic/prefetch_top.sv */
// prefetch top level: code-segment window, APB fetcher, wait timer and decoder FIFO.
`timescale 1ns/1ps

module prefetch_top
    import prefetch_pkg::*;
#(
    parameter int FIFO_DEPTH     = 4,
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic       clk,
    input  logic       pr_reset,
    // window reload.
    input  logic       flush,
    input  addr_t      eip,
    input  logic [1:0] cpl,
    input  cs_desc_t   cs_desc,
    // APB read master.
    output addr_t      paddr,
    output logic       psel,
    output logic       penable,
    output logic       pprot_priv,
    input  word_t      prdata,
    input  logic       pready,
    input  logic       pslverr,
    // decoder side.
    output logic       out_valid,
    output word_t      out_data,
    output byte_cnt_t  out_count,
    input  logic       out_ready,
    // status.
    output logic       limit_hit,
    output logic       fault,
    output fault_e     fault_cause
);

    logic       counting;
    logic       expired;
    logic [2:0] occupancy;
    logic       push;
    word_t      push_data;
    byte_cnt_t  push_count;

    fetch_req_if req_if ();

    prefetch_window u_window (
        .clk       (clk),
        .pr_reset  (pr_reset),
        .flush     (flush),
        .eip       (eip),
        .cs_desc   (cs_desc),
        .req       (req_if.window),
        .limit_hit (limit_hit)
    );

    fetch_fsm #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetch (
        .clk         (clk),
        .pr_reset    (pr_reset),
        .flush       (flush),
        .cpl         (cpl),
        .req         (req_if.fetcher),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pprot_priv  (pprot_priv),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .counting    (counting),
        .expired     (expired),
        .occupancy   (occupancy),
        .push        (push),
        .push_data   (push_data),
        .push_count  (push_count),
        .fault       (fault),
        .fault_cause (fault_cause)
    );

    fetch_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timer (
        .clk      (clk),
        .pr_reset (pr_reset),
        .counting (counting),
        .expired  (expired)
    );

    prefetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .pr_reset   (pr_reset),
        .flush      (flush),
        .push       (push),
        .push_data  (push_data),
        .push_count (push_count),
        .occupancy  (occupancy),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_count  (out_count),
        .out_ready  (out_ready)
    );

endmodule

/* logic/prefetch_window.sv */
// code-segment window: tracks linear fetch address, remaining byte budget and limit pulse.
`timescale 1ns/1ps

module prefetch_window
    import prefetch_pkg::*;
(
    input  logic       clk,
    input  logic       pr_reset,
    input  logic       flush,
    input  addr_t      eip,
    input  cs_desc_t   cs_desc,
    fetch_req_if.window req,
    output logic       limit_hit
);

    addr_t linear;
    addr_t budget;
    logic  limit_signaled;
    addr_t cs_base;
    addr_t cs_limit;

    // decode the new descriptor; only used on flush.
    assign cs_base  = desc_base(cs_desc);
    assign cs_limit = desc_limit(cs_desc);

    // window values go straight to the fetcher.
    assign req.address = linear;
    assign req.budget  = budget;

    // first cycle with nothing left, once per flush.
    assign limit_hit = (budget == '0) && !limit_signaled;

    // remaining bytes up to and including the limit byte.
    always_ff @(posedge clk) begin
        if (pr_reset) begin
            budget <= '0;
        end else if (flush) begin
            // eip past the limit leaves nothing to fetch.
            budget <= (cs_limit >= eip) ? cs_limit - eip + addr_t'(1) : '0;
        end else if (req.done) begin
            budget <= budget - addr_t'(req.done_count);
        end
    end

    // linear address advances by the bytes consumed.
    always_ff @(posedge clk) begin
        if (pr_reset) begin
            linear <= '0;
        end else if (flush) begin
            linear <= cs_base + eip;
        end else if (req.done) begin
            linear <= linear + addr_t'(req.done_count);
        end
    end

    // remembers that the pulse for this flush was given.
    always_ff @(posedge clk) begin
        if (pr_reset) begin
            limit_signaled <= 1'b0;
        end else if (flush) begin
            limit_signaled <= 1'b0;
        end else if (limit_hit) begin
            limit_signaled <= 1'b1;
        end
    end

endmodule

/* tb/prefetch_patterns.txt */
// columns: cs_desc eip cpl bus_error_word hang mid_flush_eip | bytes limit_pulses fault_cause
// ffffffff marks no bus error word or no second flush; fault 0 none, 1 slave error, 2 timeout
00009a001000003f 00000000 0 ffffffff 0 ffffffff 00000040 1 0
00009a002001002c 00000006 0 ffffffff 0 ffffffff 00000027 1 0
00009a001000003f 00000040 0 ffffffff 0 ffffffff 00000000 1 0
00009a001000003f 0000003f 3 ffffffff 0 ffffffff 00000001 1 0
10809a0000000000 00000fd0 3 ffffffff 0 ffffffff 00000030 1 0
00009a001000003f 00000002 0 00001010 0 ffffffff 0000000e 0 1
00009a001000003f 00000030 0 ffffffff 0 ffffffff 00000010 1 0
00009a001000003f 00000000 0 ffffffff 1 ffffffff 00000000 0 2
00009a001000003f 00000010 3 ffffffff 0 00000021 0000001f 1 0
00009a003000007f 00000001 1 ffffffff 0 ffffffff 0000007f 1 0

/* tb/tb_clock_gen.sv */
// testbench clock and reset source: 100 ns clock, reset held for the first cycles.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic pr_reset
);

    // free-running clock, low at time zero.
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // synchronous reset, released on a rising edge.
    initial begin
        pr_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        pr_reset <= 1'b0;
    end

endmodule

/* tb/tb_prefetch.sv */
// prefetch testbench: replays flush scenarios against an APB slave model and a decoder sink.
`timescale 1ns/1ps

module tb_prefetch
    import prefetch_pkg::*;
();

    localparam int          FIFO_DEPTH     = 4;
    localparam int          TIMEOUT_CYCLES = 16;
    localparam int          NUM_PATTERNS   = 10;
    localparam int          FIELDS         = 9;
    localparam int          POOL_SIZE      = 4096;
    localparam logic [31:0] RAND_SEED      = 32'h7f8d2ab8;
    localparam word_t       MODEL_XOR      = 32'h5a5a0000;

    logic       clk;
    logic       pr_reset;
    // DUT inputs, all defined from time zero.
    logic       flush     = 1'b0;
    addr_t      eip       = '0;
    logic [1:0] cpl       = 2'd0;
    cs_desc_t   cs_desc   = '0;
    word_t      prdata    = '0;
    logic       pready    = 1'b0;
    logic       pslverr   = 1'b0;
    logic       out_ready = 1'b0;
    // DUT outputs.
    addr_t      paddr;
    logic       psel;
    logic       penable;
    logic       pprot_priv;
    logic       out_valid;
    word_t      out_data;
    byte_cnt_t  out_count;
    logic       limit_hit;
    logic       fault;
    fault_e     fault_cause;

    // scenario table and random pool.
    logic [63:0] pattern_mem [NUM_PATTERNS * FIELDS];
    int unsigned rand_pool [POOL_SIZE];
    int          rand_idx = 0;
    // slave model setup for the running scenario.
    addr_t       err_word = '1;
    logic        hang     = 1'b0;
    int          wait_left;
    // observations gathered on the falling edge.
    string       test_name = "reset";
    addr_t       exp_addr;
    int          got_total = 0;
    int          limit_cnt = 0;
    int          starts    = 0;
    int          level     = 0;
    int          lane;
    logic [1:0]  flush_cpl = 2'd0;
    logic        discard_seen = 1'b0;
    logic        prev_psel  = 1'b0;
    logic        last_valid = 1'b0;
    logic        last_psel  = 1'b0;
    logic        last_setup = 1'b0;
    logic        last_fault = 1'b0;
    fault_e      last_cause = FAULT_NONE;
    int          cycle_cnt   = 0;
    int          cycle_limit = 200;

    tb_clock_gen clock_gen (
        .clk      (clk),
        .pr_reset (pr_reset)
    );

    prefetch_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) uut (
        .clk         (clk),
        .pr_reset    (pr_reset),
        .flush       (flush),
        .eip         (eip),
        .cpl         (cpl),
        .cs_desc     (cs_desc),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pprot_priv  (pprot_priv),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_count   (out_count),
        .out_ready   (out_ready),
        .limit_hit   (limit_hit),
        .fault       (fault),
        .fault_cause (fault_cause)
    );

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bytes(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_fault(input string name, input fault_e expected, input fault_e actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %s actual %s", name, expected.name(), actual.name());
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %b actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    // memory image seen through the slave: word address xor a constant, byte at its lane.
    function automatic logic [7:0] model_byte(input addr_t addr);
        word_t word;
        word = {addr[31:2], 2'b00} ^ MODEL_XOR;
        return word[8 * addr[1:0] +: 8];
    endfunction

    function automatic int unsigned next_rand();
        next_rand = rand_pool[rand_idx];
        rand_idx  = (rand_idx + 1) % POOL_SIZE;
    endfunction

    // loads a new window; returns one edge later with flush low again.
    task automatic apply_flush(input cs_desc_t desc, input addr_t new_eip, input logic [1:0] new_cpl);
        flush   <= 1'b1;
        cs_desc <= desc;
        eip     <= new_eip;
        cpl     <= new_cpl;
        @(posedge clk);
        flush   <= 1'b0;
    endtask

    // APB slave with 0 to 3 wait states, plus the stalling decoder.
    always @(posedge clk) begin
        if (pr_reset) begin
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            out_ready <= 1'b0;
            wait_left = 0;
        end else begin
            // decoder takes a group about one cycle in eight, so the FIFO fills up.
            out_ready <= (next_rand() % 8) == 0;
            if (psel && (!penable || !pready)) begin
                if (!penable) begin
                    wait_left = int'(next_rand() % 4);
                end else if (wait_left > 0) begin
                    wait_left = wait_left - 1;
                end
                // a hung slave never completes.
                if (!hang && wait_left == 0) begin
                    pready  <= 1'b1;
                    prdata  <= {paddr[31:2], 2'b00} ^ MODEL_XOR;
                    pslverr <= (paddr == err_word);
                end
            end else begin
                pready  <= 1'b0;
                pslverr <= 1'b0;
            end
        end
    end

    // mid-cycle sampling of the decoder stream and the bus.
    always @(negedge clk) begin
        if (!pr_reset) begin
            if (out_valid && out_ready) begin
                for (lane = 0; lane < int'(out_count); lane++) begin
                    check_bytes($sformatf("%s byte %0d", test_name, got_total),
                                model_byte(exp_addr), out_data[8 * lane +: 8]);
                    exp_addr  = exp_addr + 1;
                    got_total = got_total + 1;
                end
                level = level - 1;
            end
            // a completed word counts only if it belongs to the current window.
            if (psel && penable && pready && !pslverr && !discard_seen && !flush) begin
                level = level + 1;
            end
            if (psel && !prev_psel) begin
                check_bit({test_name, " fifo not full at psel"}, 1'b1, level < FIFO_DEPTH);
                check_bit({test_name, " pprot_priv"}, flush_cpl != 2'd3, pprot_priv);
                starts = starts + 1;
            end
            if (limit_hit) begin
                limit_cnt = limit_cnt + 1;
            end
            if (!psel) begin
                discard_seen = 1'b0;
            end
            // new window restarts all expectations.
            if (flush) begin
                if (psel) begin
                    discard_seen = 1'b1;
                end
                level     = 0;
                got_total = 0;
                limit_cnt = 0;
                starts    = 0;
                exp_addr  = desc_base(cs_desc) + eip;
                flush_cpl = cpl;
            end
        end
        prev_psel  = psel;
        last_valid = out_valid;
        last_psel  = psel;
        last_setup = psel && !penable;
        last_fault = fault;
        last_cause = fault_cause;
    end

    // run limit scaled to the number of bytes in the table.
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped after %0d cycles before all scenarios completed", cycle_cnt);
            stop_on_error();
        end
    end

    initial begin
        cs_desc_t   p_desc;
        addr_t      p_eip;
        addr_t      p_mid;
        logic [1:0] p_cpl;
        addr_t      exp_total;
        addr_t      exp_limit;
        fault_e     exp_fault;
        addr_t      byte_sum;
        int         idx;
        void'($urandom(RAND_SEED));
        for (idx = 0; idx < POOL_SIZE; idx++) begin
            rand_pool[idx] = $urandom;
        end
        $readmemh("tb/prefetch_patterns.txt", pattern_mem);
        if ($isunknown(pattern_mem[NUM_PATTERNS * FIELDS - 1])) begin
            $display("pattern file tb/prefetch_patterns.txt is missing or too short");
            stop_on_error();
        end
        byte_sum = '0;
        for (idx = 0; idx < NUM_PATTERNS; idx++) begin
            byte_sum = byte_sum + addr_t'(pattern_mem[idx * FIELDS + 6]);
        end
        cycle_limit = 64 * int'(byte_sum) + 200;

        // budget is zero out of reset, so one limit pulse follows.
        @(negedge clk);
        while (pr_reset) @(negedge clk);
        check_bit("limit pulse after reset", 1'b1, limit_hit);
        check_bit("psel after reset", 1'b0, psel);
        check_bit("penable after reset", 1'b0, penable);
        check_bit("out_valid after reset", 1'b0, out_valid);
        check_bit("fault after reset", 1'b0, fault);
        @(negedge clk);
        check_bit("single limit pulse after reset", 1'b0, limit_hit);

        for (idx = 0; idx < NUM_PATTERNS; idx++) begin
            p_desc    = pattern_mem[idx * FIELDS + 0];
            p_eip     = addr_t'(pattern_mem[idx * FIELDS + 1]);
            p_cpl     = pattern_mem[idx * FIELDS + 2][1:0];
            p_mid     = addr_t'(pattern_mem[idx * FIELDS + 5]);
            exp_total = addr_t'(pattern_mem[idx * FIELDS + 6]);
            exp_limit = addr_t'(pattern_mem[idx * FIELDS + 7]);
            exp_fault = fault_e'(pattern_mem[idx * FIELDS + 8][1:0]);
            @(posedge clk);
            test_name = $sformatf("pattern %0d", idx);
            err_word <= addr_t'(pattern_mem[idx * FIELDS + 3]);
            hang     <= pattern_mem[idx * FIELDS + 4][0];
            apply_flush(p_desc, p_eip, p_cpl);
            // second flush lands in the first access cycle.
            if (p_mid != '1) begin
                do @(posedge clk); while (!last_setup);
                apply_flush(p_desc, p_mid, p_cpl);
            end
            // a fault case ends once the fault shows and the decoder has drained.
            do begin
                @(posedge clk);
            end while (!((exp_fault != FAULT_NONE) ? (last_fault && !last_valid) :
                         ((limit_cnt != 0) && !last_valid && !last_psel)));
            // a few more cycles to catch a repeated limit pulse.
            repeat (3) @(posedge clk);
            check_count({test_name, " byte total"}, exp_total, addr_t'(got_total));
            check_count({test_name, " limit pulses"}, exp_limit, addr_t'(limit_cnt));
            check_fault({test_name, " fault cause"}, exp_fault, last_cause);
            check_bit({test_name, " fault"}, exp_fault != FAULT_NONE, last_fault);
            if (exp_total == '0 && exp_fault == FAULT_NONE) begin
                check_count({test_name, " transfers"}, '0, addr_t'(starts));
            end
            if (exp_fault == FAULT_TIMEOUT) begin
                check_bit({test_name, " psel released"}, 1'b0, last_psel);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule
